//--- logic/sdp_pkg.sv
package sdp_pkg;

  // ====================
  // widths.
  localparam int narrow_w   = 32;                  // one stream beat.
  localparam int wide_w     = 128;                 // one unpacked word.
  localparam int pack_ratio = wide_w / narrow_w;   // beats per word.
  localparam int elem_w     = 16;
  localparam int lane_n     = wide_w / elem_w;     // elements per word.
  localparam int len_w      = 8;                   // layer length in words.
  localparam int seg_w      = $clog2(pack_ratio);
  localparam int beat_w     = len_w + seg_w;       // beats per layer.

  // index of the top segment of a word.
  localparam logic [seg_w-1:0] seg_last = seg_w'(pack_ratio - 1);

  // saturation limits of one element.
  localparam logic [elem_w-1:0] elem_max = {1'b0, {(elem_w-1){1'b1}}};
  localparam logic [elem_w-1:0] elem_min = {1'b1, {(elem_w-1){1'b0}}};

  // ====================
  // opcodes and states.
  typedef enum logic [1:0] {
    op_bypass    = 2'd0,  // unchanged.
    op_bias      = 2'd1,  // saturating bias add.
    op_relu      = 2'd2,
    op_bias_relu = 2'd3   // bias add, then relu.
  } sdp_op_e;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_run   = 2'd1,
    st_drain = 2'd2
  } sdp_state_e;

  // ====================
  // layer config, 26 bits. len of zero means 256 words.
  typedef struct packed {
    sdp_op_e                  op;
    logic signed [elem_w-1:0] bias;
    logic [len_w-1:0]         len;
  } sdp_cfg_t;

  typedef logic [narrow_w-1:0] narrow_t;

  // lane 0 sits in the low bits.
  typedef logic [lane_n-1:0][elem_w-1:0] wide_t;

endpackage

//--- logic/sdp_core_unpack.sv
`timescale 1ns/1ps

module sdp_core_unpack (
  input  logic             autosa_core_clk,
  input  logic             autosa_core_rstn,
  input  logic             inp_pvld,
  output logic             inp_prdy,
  input  sdp_pkg::narrow_t inp_data,
  output logic             out_pvld,
  input  logic             out_prdy,
  output sdp_pkg::wide_t   out_data
);

  logic [sdp_pkg::seg_w-1:0]                            pack_cnt;
  logic                                                 pack_pvld;
  logic                                                 inp_acc;
  logic                                                 is_pack_last;
  logic [sdp_pkg::pack_ratio-1:0][sdp_pkg::narrow_w-1:0] seg_q;

  // ====================
  // handshake.

  // a held word blocks new beats until it leaves.
  assign inp_prdy     = !pack_pvld || out_prdy;
  assign inp_acc      = inp_pvld && inp_prdy;
  assign is_pack_last = (pack_cnt == sdp_pkg::seg_last);
  assign out_pvld     = pack_pvld;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      pack_pvld <= 1'b0;
    end else if (inp_prdy) begin
      pack_pvld <= inp_pvld && is_pack_last;  // word complete.
    end
  end

  // beat counter.
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      pack_cnt <= '0;
    end else if (inp_acc) begin
      if (is_pack_last) begin
        pack_cnt <= '0;
      end else begin
        pack_cnt <= pack_cnt + 1'b1;
      end
    end
  end

  // ====================
  // segment store, beat 0 in the low bits.
  always_ff @(posedge autosa_core_clk) begin
    if (inp_acc) begin
      seg_q[pack_cnt] <= inp_data;
    end
  end

  assign out_data = seg_q;

  a_cnt_range: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    pack_cnt <= sdp_pkg::seg_last
  ) else $error("unpack beat counter out of range.");

endmodule

//--- logic/sdp_core_alu.sv
`timescale 1ns/1ps

module sdp_core_alu (
  input  logic              autosa_core_clk,
  input  logic              autosa_core_rstn,
  input  sdp_pkg::sdp_cfg_t cfg_q,
  input  logic              inp_pvld,
  output logic              inp_prdy,
  input  sdp_pkg::wide_t    inp_data,
  output logic              out_pvld,
  input  logic              out_prdy,
  output sdp_pkg::wide_t    out_data
);

  sdp_pkg::wide_t res_next;
  logic           use_bias;
  logic           use_relu;

  // ====================
  // per-lane rule.

  // signed add, clamped to the element range.
  function automatic logic [sdp_pkg::elem_w-1:0] sat_add(
    input logic [sdp_pkg::elem_w-1:0] a,
    input logic [sdp_pkg::elem_w-1:0] b
  );
    logic [sdp_pkg::elem_w:0] sum;
    logic [sdp_pkg::elem_w-1:0] res;
    sum = {a[sdp_pkg::elem_w-1], a} + {b[sdp_pkg::elem_w-1], b};
    if (sum[sdp_pkg::elem_w] == sum[sdp_pkg::elem_w-1]) begin
      res = sum[sdp_pkg::elem_w-1:0];
    end else if (sum[sdp_pkg::elem_w]) begin
      res = sdp_pkg::elem_min;  // negative overflow.
    end else begin
      res = sdp_pkg::elem_max;
    end
    return res;
  endfunction

  always_comb begin
    use_bias = 1'b0;
    use_relu = 1'b0;
    unique case (cfg_q.op)
      sdp_pkg::op_bypass: begin
      end
      sdp_pkg::op_bias: use_bias = 1'b1;
      sdp_pkg::op_relu: use_relu = 1'b1;
      sdp_pkg::op_bias_relu: begin
        use_bias = 1'b1;
        use_relu = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < sdp_pkg::lane_n; i++) begin
      res_next[i] = use_bias ? sat_add(inp_data[i], cfg_q.bias) : inp_data[i];
      if (use_relu && res_next[i][sdp_pkg::elem_w-1]) begin
        res_next[i] = '0;  // negative clamps to zero.
      end
    end
  end

  // ====================
  // one pipeline stage.
  assign inp_prdy = !out_pvld || out_prdy;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      out_pvld <= 1'b0;
    end else if (inp_prdy) begin
      out_pvld <= inp_pvld;
    end
  end

  always_ff @(posedge autosa_core_clk) begin
    if (inp_pvld && inp_prdy) begin
      out_data <= res_next;
    end
  end

  a_hold_data: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    out_pvld && !out_prdy |=> $stable(out_data)
  ) else $error("alu result changed while stalled.");

endmodule

//--- logic/sdp_core_pack.sv
`timescale 1ns/1ps

module sdp_core_pack (
  input  logic             autosa_core_clk,
  input  logic             autosa_core_rstn,
  input  logic             inp_pvld,
  output logic             inp_prdy,
  input  sdp_pkg::wide_t   inp_data,
  output logic             out_pvld,
  input  logic             out_prdy,
  output sdp_pkg::narrow_t out_data
);

  logic [sdp_pkg::pack_ratio-1:0][sdp_pkg::narrow_w-1:0] word_q;
  logic [sdp_pkg::seg_w-1:0]                            seg_idx;
  logic                                                 out_acc;
  logic                                                 is_seg_last;

  assign out_acc     = out_pvld && out_prdy;
  assign is_seg_last = (seg_idx == sdp_pkg::seg_last);

  // free when empty or the top segment leaves now.
  assign inp_prdy = !out_pvld || (out_prdy && is_seg_last);

  // ====================
  // word and segment index.
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      out_pvld <= 1'b0;
      seg_idx  <= '0;
    end else if (inp_pvld && inp_prdy) begin
      out_pvld <= 1'b1;
      seg_idx  <= '0;  // restart at the low segment.
    end else if (out_acc) begin
      if (is_seg_last) begin
        out_pvld <= 1'b0;
      end else begin
        seg_idx <= seg_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge autosa_core_clk) begin
    if (inp_pvld && inp_prdy) begin
      word_q <= inp_data;
    end
  end

  assign out_data = word_q[seg_idx];  // lowest segment first.

  a_pvld_hold: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    out_pvld && !out_prdy |=> out_pvld
  ) else $error("pack valid dropped before acceptance.");

endmodule

//--- logic/sdp_core_ctrl.sv
`timescale 1ns/1ps

module sdp_core_ctrl (
  input  logic              autosa_core_clk,
  input  logic              autosa_core_rstn,
  input  sdp_pkg::sdp_cfg_t cfg,
  input  logic              start,
  input  logic              inp_acc,
  input  logic              out_acc,
  output sdp_pkg::sdp_cfg_t cfg_q,
  output logic              in_gate,
  output logic              busy,
  output logic              done
);

  sdp_pkg::sdp_state_e           state;
  logic [sdp_pkg::beat_w-1:0]    in_cnt;
  logic [sdp_pkg::beat_w-1:0]    out_cnt;
  logic [sdp_pkg::len_w-1:0]     len_m1;
  logic [sdp_pkg::beat_w-1:0]    last_beat;
  logic                          in_last;
  logic                          out_last;

  // ====================
  // layer length in beats.

  // len of zero wraps to 255 and so counts 256 words.
  assign len_m1    = cfg_q.len - 1'b1;
  assign last_beat = {len_m1, sdp_pkg::seg_last};
  assign in_last   = inp_acc && (in_cnt == last_beat);
  assign out_last  = out_acc && (out_cnt == last_beat);

  assign in_gate = (state == sdp_pkg::st_run);
  assign busy    = (state != sdp_pkg::st_idle);

  // ====================
  // layer FSM.
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      state   <= sdp_pkg::st_idle;
      cfg_q   <= '0;
      in_cnt  <= '0;
      out_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      unique case (state)
        sdp_pkg::st_idle: begin
          if (start) begin
            cfg_q   <= cfg;
            in_cnt  <= '0;
            out_cnt <= '0;
            state   <= sdp_pkg::st_run;
          end
        end
        sdp_pkg::st_run: begin
          if (inp_acc) in_cnt <= in_cnt + 1'b1;
          if (out_acc) out_cnt <= out_cnt + 1'b1;
          if (in_last) state <= sdp_pkg::st_drain;  // close the input.
        end
        sdp_pkg::st_drain: begin
          if (out_acc) out_cnt <= out_cnt + 1'b1;
          if (out_last) begin
            state <= sdp_pkg::st_idle;
            done  <= 1'b1;
          end
        end
        default: state <= sdp_pkg::st_idle;
      endcase
    end
  end

  // start during a layer is dropped.
  a_start_busy: assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !(start && busy)
  ) else $warning("start ignored while busy.");

endmodule

//--- logic/sdp_core.sv
`timescale 1ns/1ps

module sdp_core (
  input  logic              autosa_core_clk,
  input  logic              autosa_core_rstn,
  input  sdp_pkg::sdp_cfg_t cfg,
  input  logic              start,
  output logic              busy,
  output logic              done,
  input  logic              inp_pvld,
  output logic              inp_prdy,
  input  sdp_pkg::narrow_t  inp_data,
  output logic              out_pvld,
  input  logic              out_prdy,
  output sdp_pkg::narrow_t  out_data
);

  sdp_pkg::sdp_cfg_t cfg_q;
  logic              in_gate;
  logic              unp_pvld;
  logic              unp_prdy;
  logic              inp_acc;
  logic              out_acc;
  logic              word_pvld;
  logic              word_prdy;
  sdp_pkg::wide_t    word_data;
  logic              res_pvld;
  logic              res_prdy;
  sdp_pkg::wide_t    res_data;

  // ====================
  // input gating and transfer strobes.
  assign unp_pvld = inp_pvld && in_gate;
  assign inp_prdy = unp_prdy && in_gate;  // closed outside a layer.
  assign inp_acc  = unp_pvld && unp_prdy;
  assign out_acc  = out_pvld && out_prdy;

  sdp_core_ctrl u_ctrl (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .cfg              (cfg),
    .start            (start),
    .inp_acc          (inp_acc),
    .out_acc          (out_acc),
    .cfg_q            (cfg_q),
    .in_gate          (in_gate),
    .busy             (busy),
    .done             (done)
  );

  // ====================
  // datapath.
  sdp_core_unpack u_unpack (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .inp_pvld         (unp_pvld),
    .inp_prdy         (unp_prdy),
    .inp_data         (inp_data),
    .out_pvld         (word_pvld),
    .out_prdy         (word_prdy),
    .out_data         (word_data)
  );

  sdp_core_alu u_alu (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .cfg_q            (cfg_q),
    .inp_pvld         (word_pvld),
    .inp_prdy         (word_prdy),
    .inp_data         (word_data),
    .out_pvld         (res_pvld),
    .out_prdy         (res_prdy),
    .out_data         (res_data)
  );

  sdp_core_pack u_pack (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .inp_pvld         (res_pvld),
    .inp_prdy         (res_prdy),
    .inp_data         (res_data),
    .out_pvld         (out_pvld),
    .out_prdy         (out_prdy),
    .out_data         (out_data)
  );

endmodule

//--- testbench/sdp_core_tb_checks.svh
// ====================
// reference model.

// one element through the op on plain integers.
function automatic logic [sdp_pkg::elem_w-1:0] ref_elem(
  sdp_pkg::sdp_op_e           op,
  logic [sdp_pkg::elem_w-1:0] bias,
  logic [sdp_pkg::elem_w-1:0] e
);
  int v;
  v = int'($signed(e));
  if (op == sdp_pkg::op_bias || op == sdp_pkg::op_bias_relu) begin
    v = v + int'($signed(bias));
  end
  if (v > 32767) v = 32767;    // clamp to 16'h7fff.
  if (v < -32768) v = -32768;  // clamp to 16'h8000.
  if ((op == sdp_pkg::op_relu || op == sdp_pkg::op_bias_relu) && v < 0) v = 0;
  return v[sdp_pkg::elem_w-1:0];
endfunction

// beat k carries elements 2k and 2k+1 with the low half first.
function automatic sdp_pkg::narrow_t in_beat(sdp_pkg::wide_t w, int k);
  return {w[2*k+1], w[2*k]};
endfunction

function automatic sdp_pkg::wide_t rand_word();
  return {$urandom, $urandom, $urandom, $urandom};
endfunction

task automatic expect_word(sdp_pkg::sdp_cfg_t c, sdp_pkg::wide_t w);
  sdp_pkg::wide_t r;
  for (int i = 0; i < sdp_pkg::lane_n; i++) begin
    r[i] = ref_elem(c.op, c.bias, w[i]);
  end
  for (int k = 0; k < sdp_pkg::pack_ratio; k++) begin
    exp_q.push_back(in_beat(r, k));
  end
endtask

// ====================
// compare tasks.
task automatic check_beat(string name, sdp_pkg::narrow_t got, sdp_pkg::narrow_t exp);
  check_cnt++;
  if (got !== exp) begin
    $display("MISMATCH %s got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_flag(string name, logic got, logic exp);
  check_cnt++;
  if (got !== exp) begin
    $display("MISMATCH %s got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_count(string name, int got, int exp);
  check_cnt++;
  if (got != exp) begin
    $display("MISMATCH %s got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

//--- testbench/sdp_core_tb.sv
`timescale 1ns/1ps

module sdp_core_tb;

  localparam int max_wait = 1000;  // cycles per wait.

  logic              autosa_core_clk;
  logic              autosa_core_rstn;
  sdp_pkg::sdp_cfg_t cfg;
  logic              start;
  logic              busy;
  logic              done;
  logic              inp_pvld;
  logic              inp_prdy;
  sdp_pkg::narrow_t  inp_data;
  logic              out_pvld;
  logic              out_prdy;
  sdp_pkg::narrow_t  out_data;

  sdp_pkg::narrow_t  exp_q[$];   // expected output beats in order.
  sdp_pkg::wide_t    word_q[$];  // words of the current layer.
  int                err_cnt = 0;
  int                err_mark = 0;
  int                check_cnt = 0;
  int                test_cnt = 0;
  int                done_cnt = 0;
  bit                stall_en = 1'b0;

  // lanes at and near both limits.
  localparam sdp_pkg::wide_t edge_word = {16'h7fff, 16'h7f00, 16'h0001, 16'hffff,
                                          16'h8000, 16'h80ff, 16'h0000, 16'hc000};

  `include "sdp_core_tb_checks.svh"

  sdp_core dut0 (.*);

  initial begin
    autosa_core_clk = 1'b0;
    forever #20 autosa_core_clk = ~autosa_core_clk;
  end

  // sink ready goes random while stalls are on.
  initial begin
    out_prdy = 1'b1;
    forever begin
      @(posedge autosa_core_clk);
      out_prdy <= stall_en ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  // ====================
  // output monitor at mid-cycle.
  always @(negedge autosa_core_clk) begin
    if (out_pvld && out_prdy) begin
      if (exp_q.size() == 0) begin
        $display("unexpected output beat %h", out_data);
        err_cnt++;
      end else begin
        check_beat("out_data", out_data, exp_q.pop_front());
      end
    end
    if (done) done_cnt++;
  end

  task automatic abort_run(string why);
    $display("timeout: %s", why);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic finish_test(string name);
    test_cnt++;
    $display("test %s finished with %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // hold one beat until it is taken.
  task automatic send_beat(sdp_pkg::narrow_t b);
    int t;
    inp_pvld <= 1'b1;
    inp_data <= b;
    for (t = 0; t < max_wait; t++) begin
      @(negedge autosa_core_clk);
      if (inp_prdy) break;
    end
    if (t == max_wait) abort_run("an input beat was never accepted.");
    @(posedge autosa_core_clk);
  endtask

  task automatic wait_done(bit closed);
    int t;
    for (t = 0; t < max_wait; t++) begin
      @(negedge autosa_core_clk);
      if (closed) check_flag("inp_prdy", inp_prdy, 1'b0);
      if (done) break;
      check_flag("busy", busy, 1'b1);
    end
    if (t == max_wait) abort_run("done never pulsed.");
    check_flag("busy", busy, 1'b0);
    check_count("beats still expected", exp_q.size(), 0);
  endtask

  // start a layer, feed every word of word_q and wait for done.
  task automatic run_layer(sdp_pkg::sdp_cfg_t c, bit gaps);
    int n_done;
    int n;
    n_done = done_cnt;
    n = word_q.size();
    c.len = n[sdp_pkg::len_w-1:0];
    foreach (word_q[i]) expect_word(c, word_q[i]);
    cfg   <= c;
    start <= 1'b1;
    @(posedge autosa_core_clk);
    start <= 1'b0;
    foreach (word_q[i]) begin
      for (int k = 0; k < sdp_pkg::pack_ratio; k++) begin
        if (gaps && $urandom_range(2) == 0) begin
          inp_pvld <= 1'b0;
          repeat ($urandom_range(3) + 1) @(posedge autosa_core_clk);
        end
        send_beat(in_beat(word_q[i], k));
      end
    end
    inp_pvld <= 1'b0;
    wait_done(1'b0);
    repeat (3) @(posedge autosa_core_clk);
    check_count("done pulses", done_cnt, n_done + 1);
  endtask

  task automatic op_layer(sdp_pkg::sdp_op_e op, logic [15:0] bias, int n, bit with_edge);
    sdp_pkg::sdp_cfg_t c;
    word_q.delete();
    if (with_edge) word_q.push_back(edge_word);
    repeat (n) word_q.push_back(rand_word());
    c.op   = op;
    c.bias = bias;
    c.len  = '0;
    run_layer(c, stall_en);
  endtask

  // ====================
  // directed tests.
  task automatic test_control();
    sdp_pkg::sdp_cfg_t c;
    int n_done;
    @(negedge autosa_core_clk);
    check_flag("busy", busy, 1'b0);
    check_flag("out_pvld", out_pvld, 1'b0);
    @(posedge autosa_core_clk);
    word_q.delete();
    word_q.push_back(rand_word());
    c.op   = sdp_pkg::op_bypass;
    c.bias = '0;
    c.len  = 8'd1;
    expect_word(c, word_q[0]);
    n_done = done_cnt;
    cfg   <= c;
    start <= 1'b1;
    @(posedge autosa_core_clk);
    start <= 1'b0;
    send_beat(in_beat(word_q[0], 0));
    send_beat(in_beat(word_q[0], 1));
    cfg.len <= 8'd5;  // restart with a longer layer while busy.
    start   <= 1'b1;
    send_beat(in_beat(word_q[0], 2));
    start <= 1'b0;
    send_beat(in_beat(word_q[0], 3));
    inp_data <= $urandom;  // one beat past the layer stays on offer.
    wait_done(1'b1);
    repeat (4) begin
      @(negedge autosa_core_clk);
      check_flag("inp_prdy", inp_prdy, 1'b0);
      check_flag("busy", busy, 1'b0);
    end
    @(posedge autosa_core_clk);
    inp_pvld <= 1'b0;
    check_count("done pulses", done_cnt, n_done + 1);
    finish_test("control");
  endtask

  task automatic test_bias();
    op_layer(sdp_pkg::op_bias, 16'h0100, 1, 1'b1);
    op_layer(sdp_pkg::op_bias, 16'hff00, 1, 1'b1);
    op_layer(sdp_pkg::op_bias, 16'h7fff, 1, 1'b1);
    op_layer(sdp_pkg::op_bias, 16'h8000, 1, 1'b1);
    finish_test("bias");
  endtask

  task automatic test_relu();
    op_layer(sdp_pkg::op_relu, 16'h0000, 2, 1'b1);
    op_layer(sdp_pkg::op_bias_relu, 16'h0002, 2, 1'b1);
    op_layer(sdp_pkg::op_bias_relu, 16'hc000, 2, 1'b1);
    finish_test("relu");
  endtask

  initial begin
    void'($urandom(32'h5926156f));
    autosa_core_rstn = 1'b0;
    cfg      = '0;
    start    = 1'b0;
    inp_pvld = 1'b0;
    inp_data = '0;
    repeat (2) @(posedge autosa_core_clk);
    autosa_core_rstn <= 1'b1;
    @(posedge autosa_core_clk);
    test_control();
    op_layer(sdp_pkg::op_bypass, 16'h7fff, 3, 1'b0);
    finish_test("bypass");
    test_bias();
    test_relu();
    stall_en <= 1'b1;  // sink stalls and source gaps.
    @(posedge autosa_core_clk);
    op_layer(sdp_pkg::op_bias, 16'h0003, 10, 1'b0);
    stall_en <= 1'b0;
    finish_test("backpressure");
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+testbench
logic/sdp_pkg.sv
logic/sdp_core_unpack.sv
logic/sdp_core_alu.sv
logic/sdp_core_pack.sv
logic/sdp_core_ctrl.sv
logic/sdp_core.sv
testbench/sdp_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sdp_core_tb
RTL_TOP   ?= sdp_core
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
